/* rv_core_consts.svh */
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// datapath and register file geometry
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define OPC_W       7
`define FUNCT3_W    3
`define FUNCT7_W    7

// major opcodes kept in this core
`define OP_IMM      7'b0010011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_REG      7'b0110011  // register-register group
`define OP_BRANCH   7'b1100011

// integer funct3 codes, shared by OP and OP_IMM
`define FUNCT3_ADD_SUB  3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SRL_SRA  3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

// branch funct3 codes
`define FUNCT3_BEQ      3'b000
`define FUNCT3_BNE      3'b001
`define FUNCT3_BLT      3'b100
`define FUNCT3_BGE      3'b101
`define FUNCT3_BLTU     3'b110
`define FUNCT3_BGEU     3'b111

`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000  // selects SUB and SRA

`endif

/* rv_core_pkg.sv */
`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS    // result is opa, used by LUI
    } alu_op_e;

    typedef enum logic {
        EXC_NONE,
        EXC_UNDEF_INSN
    } exc_e;

    typedef struct packed {
        logic [`FUNCT7_W-1:0]   funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPC_W-1:0]      opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPC_W-1:0]      opcode;
    } i_fmt_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [`OPC_W-1:0]      opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm;    // upper 20 bits of the value
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPC_W-1:0]      opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
    } rv_insn_u;

endpackage

/* rv_regfile.sv */
`timescale 1ns/10ps

`include "rv_core_consts.svh"

module rv_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]       wr_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // x0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    // asynchronous reads, x0 stays zero since it is never written
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* rv_decode.sv */
`timescale 1ns/10ps

`include "rv_core_consts.svh"

module rv_decode
    import rv_core_pkg::*;
(
    input  logic [`XLEN-1:0]       in_insn,
    input  logic [`XLEN-1:0]       in_pc,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    input  logic                   ex_valid,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic                   ex_rd_we,
    input  logic [`XLEN-1:0]       ex_value,
    input  logic                   res_valid,
    input  logic [`REG_ADDR_W-1:0] res_rd,
    input  logic                   res_we,
    input  logic [`XLEN-1:0]       res_value,
    output alu_op_e                alu_op,
    output logic [`XLEN-1:0]       opa,
    output logic [`XLEN-1:0]       opb,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic                   rd_we,
    output logic                   is_branch,
    output logic [`FUNCT3_W-1:0]   br_funct3,
    output logic [`XLEN-1:0]       br_target,
    output logic [`XLEN-1:0]       pc,
    output exc_e                   exc
);

    rv_insn_u         insn;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    alu_op_e          base_op;

    assign insn     = in_insn;
    assign rs1_addr = insn.r.rs1;   // same position in every format
    assign rs2_addr = insn.r.rs2;
    assign rd       = insn.r.rd;
    assign pc       = in_pc;

    assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
    assign imm_b = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11,
                    insn.b.imm10_5, insn.b.imm4_1, 1'b0};
    assign imm_u = {insn.u.imm, 12'b0};

    assign br_funct3 = insn.b.funct3;
    assign br_target = in_pc + imm_b;

    // execute stage is newer than result stage, x0 is never forwarded
    assign src1 = (rs1_addr == '0) ? '0 :
                  (ex_valid && ex_rd_we && ex_rd == rs1_addr) ? ex_value :
                  (res_valid && res_we && res_rd == rs1_addr) ? res_value : rs1_data;
    assign src2 = (rs2_addr == '0) ? '0 :
                  (ex_valid && ex_rd_we && ex_rd == rs2_addr) ? ex_value :
                  (res_valid && res_we && res_rd == rs2_addr) ? res_value : rs2_data;

    // funct3 meaning with funct7 at its base value
    always_comb begin
        case (insn.r.funct3)
            `FUNCT3_ADD_SUB: base_op = ALU_ADD;
            `FUNCT3_SLL:     base_op = ALU_SLL;
            `FUNCT3_SLT:     base_op = ALU_SLT;
            `FUNCT3_SLTU:    base_op = ALU_SLTU;
            `FUNCT3_XOR:     base_op = ALU_XOR;
            `FUNCT3_SRL_SRA: base_op = ALU_SRL;
            `FUNCT3_OR:      base_op = ALU_OR;
            default:         base_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op    = ALU_NOP;
        opa       = src1;
        opb       = src2;
        rd_we     = 1'b0;
        is_branch = 1'b0;
        exc       = EXC_NONE;
        case (insn.r.opcode)
            `OP_IMM: begin
                opb    = imm_i;
                rd_we  = 1'b1;
                alu_op = base_op;
                // shift immediates keep funct7 in imm[11:5]
                if (insn.r.funct3 == `FUNCT3_SLL || insn.r.funct3 == `FUNCT3_SRL_SRA) begin
                    if (insn.r.funct3 == `FUNCT3_SRL_SRA && insn.r.funct7 == `FUNCT7_ALT) begin
                        alu_op = ALU_SRA;
                    end else if (insn.r.funct7 != `FUNCT7_BASE) begin
                        exc = EXC_UNDEF_INSN;
                    end
                end
            end
            `OP_REG: begin
                rd_we = 1'b1;
                if (insn.r.funct7 == `FUNCT7_BASE) begin
                    alu_op = base_op;
                end else if (insn.r.funct7 == `FUNCT7_ALT &&
                             insn.r.funct3 == `FUNCT3_ADD_SUB) begin
                    alu_op = ALU_SUB;
                end else if (insn.r.funct7 == `FUNCT7_ALT &&
                             insn.r.funct3 == `FUNCT3_SRL_SRA) begin
                    alu_op = ALU_SRA;
                end else begin
                    exc = EXC_UNDEF_INSN;
                end
            end
            `OP_LUI: begin
                alu_op = ALU_PASS;
                opa    = imm_u;
                rd_we  = 1'b1;
            end
            `OP_AUIPC: begin
                alu_op = ALU_ADD;
                opa    = imm_u;
                opb    = in_pc;
                rd_we  = 1'b1;
            end
            `OP_BRANCH: begin
                if (insn.b.funct3 == `FUNCT3_SLT || insn.b.funct3 == `FUNCT3_SLTU) begin
                    exc = EXC_UNDEF_INSN;   // 010 and 011 are not branches
                end else begin
                    is_branch = 1'b1;
                end
            end
            default: exc = EXC_UNDEF_INSN;
        endcase
        if (exc == EXC_UNDEF_INSN) begin
            alu_op = ALU_NOP;
            rd_we  = 1'b0;
        end
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/10ps

`include "rv_core_consts.svh"

module rv_execute
    import rv_core_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   accept,
    input  alu_op_e                alu_op,
    input  logic [`XLEN-1:0]       opa,
    input  logic [`XLEN-1:0]       opb,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   rd_we,
    input  logic                   is_branch,
    input  logic [`FUNCT3_W-1:0]   br_funct3,
    input  logic [`XLEN-1:0]       br_target,
    input  logic [`XLEN-1:0]       pc,
    input  exc_e                   exc,
    output logic                   ex_valid,
    output logic [`REG_ADDR_W-1:0] ex_rd,
    output logic                   ex_rd_we,
    output logic [`XLEN-1:0]       ex_value,
    output logic                   ex_br_taken,
    output logic [`XLEN-1:0]       ex_br_target,
    output logic [`XLEN-1:0]       ex_pc,
    output exc_e                   ex_exc
);

    alu_op_e              alu_op_q;
    logic [`XLEN-1:0]     opa_q;
    logic [`XLEN-1:0]     opb_q;
    logic                 is_branch_q;
    logic [`FUNCT3_W-1:0] br_funct3_q;
    logic [4:0]           shamt;
    logic                 cond;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid    <= 1'b0;
            ex_rd_we    <= 1'b0;
            is_branch_q <= 1'b0;
        end else if (!stall) begin
            ex_valid    <= accept;  // bubble when nothing accepted
            ex_rd_we    <= accept & rd_we;
            is_branch_q <= accept & is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && accept) begin
            alu_op_q     <= alu_op;
            opa_q        <= opa;
            opb_q        <= opb;
            ex_rd        <= rd;
            br_funct3_q  <= br_funct3;
            ex_br_target <= br_target;
            ex_pc        <= pc;
            ex_exc       <= exc;
        end
    end

    assign shamt = opb_q[4:0];

    always_comb begin
        case (alu_op_q)
            ALU_ADD:  ex_value = opa_q + opb_q;
            ALU_SUB:  ex_value = opa_q - opb_q;
            ALU_SLT:  ex_value = {31'b0, $signed(opa_q) < $signed(opb_q)};
            ALU_SLTU: ex_value = {31'b0, opa_q < opb_q};
            ALU_AND:  ex_value = opa_q & opb_q;
            ALU_OR:   ex_value = opa_q | opb_q;
            ALU_XOR:  ex_value = opa_q ^ opb_q;
            ALU_SLL:  ex_value = opa_q << shamt;
            ALU_SRL:  ex_value = opa_q >> shamt;
            ALU_SRA:  ex_value = $unsigned($signed(opa_q) >>> shamt);
            ALU_PASS: ex_value = opa_q;
            default:  ex_value = '0;
        endcase
    end

    // compare on the held source operands
    always_comb begin
        case (br_funct3_q)
            `FUNCT3_BEQ:  cond = (opa_q == opb_q);
            `FUNCT3_BNE:  cond = (opa_q != opb_q);
            `FUNCT3_BLT:  cond = ($signed(opa_q) < $signed(opb_q));
            `FUNCT3_BGE:  cond = ($signed(opa_q) >= $signed(opb_q));
            `FUNCT3_BLTU: cond = (opa_q < opb_q);
            `FUNCT3_BGEU: cond = (opa_q >= opb_q);
            default:      cond = 1'b0;
        endcase
    end

    assign ex_br_taken = is_branch_q & cond;

endmodule

/* rv_result.sv */
`timescale 1ns/10ps

`include "rv_core_consts.svh"

module rv_result
    import rv_core_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   ex_valid,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic                   ex_rd_we,
    input  logic [`XLEN-1:0]       ex_value,
    input  logic                   ex_br_taken,
    input  logic [`XLEN-1:0]       ex_br_target,
    input  logic [`XLEN-1:0]       ex_pc,
    input  exc_e                   ex_exc,
    input  logic                   retire_ready,
    output logic                   retire_valid,
    output logic [`XLEN-1:0]       retire_pc,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic                   retire_we,
    output logic [`XLEN-1:0]       retire_data,
    output logic                   retire_br_taken,
    output logic [`XLEN-1:0]       retire_br_target,
    output exc_e                   retire_exc,
    output logic                   wr_en,
    output logic [`REG_ADDR_W-1:0] wr_addr,
    output logic [`XLEN-1:0]       wr_data,
    output logic                   res_valid,
    output logic [`REG_ADDR_W-1:0] res_rd,
    output logic                   res_we,
    output logic [`XLEN-1:0]       res_value
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else if (!stall) begin
            retire_valid <= ex_valid;
            retire_we    <= ex_valid & ex_rd_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            retire_pc        <= ex_pc;
            retire_rd        <= ex_rd;
            retire_data      <= ex_value;
            retire_br_taken  <= ex_br_taken;
            retire_br_target <= ex_br_target;
            retire_exc       <= ex_exc;
        end
    end

    // register write lands on the retire edge itself
    assign wr_en   = retire_valid & retire_ready & retire_we;
    assign wr_addr = retire_rd;
    assign wr_data = retire_data;

    // held record is the older forwarding source
    assign res_valid = retire_valid;
    assign res_rd    = retire_rd;
    assign res_we    = retire_we;
    assign res_value = retire_data;

endmodule

/* rv_core.sv */
`timescale 1ns/10ps

`include "rv_core_consts.svh"

module rv_core
    import rv_core_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`XLEN-1:0]       in_insn,
    input  logic [`XLEN-1:0]       in_pc,
    output logic                   retire_valid,
    input  logic                   retire_ready,
    output logic [`XLEN-1:0]       retire_pc,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic                   retire_we,
    output logic [`XLEN-1:0]       retire_data,
    output logic                   retire_br_taken,
    output logic [`XLEN-1:0]       retire_br_target,
    output exc_e                   retire_exc
);

    logic                   stall;
    logic                   accept;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   wr_en;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`XLEN-1:0]       wr_data;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       opa;
    logic [`XLEN-1:0]       opb;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_we;
    logic                   is_branch;
    logic [`FUNCT3_W-1:0]   br_funct3;
    logic [`XLEN-1:0]       br_target;
    logic [`XLEN-1:0]       pc;
    exc_e                   exc;
    logic                   ex_valid;
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic                   ex_rd_we;
    logic [`XLEN-1:0]       ex_value;
    logic                   ex_br_taken;
    logic [`XLEN-1:0]       ex_br_target;
    logic [`XLEN-1:0]       ex_pc;
    exc_e                   ex_exc;
    logic                   res_valid;
    logic [`REG_ADDR_W-1:0] res_rd;
    logic                   res_we;
    logic [`XLEN-1:0]       res_value;

    // a blocked retirement freezes both stages
    assign stall    = retire_valid & ~retire_ready;
    assign in_ready = ~stall;
    assign accept   = in_valid & in_ready;

    rv_decode  i_decode  (.*);
    rv_regfile i_regfile (.*);
    rv_execute i_execute (.*);
    rv_result  i_result  (.*);

endmodule

/* rv_core_checker.sv */
`timescale 1ns/10ps

`include "rv_core_consts.svh"

module rv_core_checker
    import rv_core_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   retire_valid,
    input  logic                   retire_ready,
    input  logic [`XLEN-1:0]       retire_pc,
    input  logic [`REG_ADDR_W-1:0] retire_rd,
    input  logic                   retire_we,
    input  logic [`XLEN-1:0]       retire_data,
    input  logic                   retire_br_taken,
    input  logic [`XLEN-1:0]       retire_br_target,
    input  exc_e                   retire_exc,
    input  logic                   exp_push,
    input  logic [`XLEN-1:0]       exp_pc,
    input  logic [`REG_ADDR_W-1:0] exp_rd,
    input  logic                   exp_we,
    input  logic [`XLEN-1:0]       exp_data,
    input  logic                   exp_taken,
    input  logic [`XLEN-1:0]       exp_target,
    input  exc_e                   exp_exc,
    output int                     n_pass,
    output int                     n_fail,
    output int                     n_pending
);

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   we;
        logic [`XLEN-1:0]       data;
        logic                   taken;
        logic [`XLEN-1:0]       target;
        exc_e                   exc;
    } exp_rec_t;

    exp_rec_t exp_q [$];    // expectations in retirement order
    int       n_tests;

    task automatic compare_field(input string name, input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] want, inout bit ok);
        if (got !== want) begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h in test %0d",
                     name, got, want, n_tests);
            ok = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        exp_rec_t e;
        exp_rec_t rec;
        bit       ok;
        // retire before push, a record never retires on its own accept edge
        if (rst_n && retire_valid && retire_ready) begin
            if (exp_q.size() == 0) begin
                $display("retirement at pc 0x%08h arrived with no expected record queued",
                         retire_pc);
                n_fail++;
            end else begin
                e  = exp_q.pop_front();
                ok = 1'b1;
                n_tests++;
                compare_field("retire_pc", retire_pc, e.pc, ok);
                compare_field("retire_we", 32'(retire_we), 32'(e.we), ok);
                compare_field("retire_exc", 32'(retire_exc), 32'(e.exc), ok);
                compare_field("retire_br_taken", 32'(retire_br_taken), 32'(e.taken), ok);
                if (e.we) begin
                    compare_field("retire_rd", 32'(retire_rd), 32'(e.rd), ok);
                    compare_field("retire_data", retire_data, e.data, ok);
                end
                // a branch is the only kept record without a write or an exception
                if (!e.we && e.exc == EXC_NONE) begin
                    compare_field("retire_br_target", retire_br_target, e.target, ok);
                end
                if (ok) begin
                    n_pass++;
                    $display("test %0d pc 0x%08h ok", n_tests, e.pc);
                end else begin
                    n_fail++;
                    $display("test %0d pc 0x%08h failed", n_tests, e.pc);
                end
            end
        end
        if (rst_n && exp_push) begin
            rec.pc     = exp_pc;
            rec.rd     = exp_rd;
            rec.we     = exp_we;
            rec.data   = exp_data;
            rec.taken  = exp_taken;
            rec.target = exp_target;
            rec.exc    = exp_exc;
            exp_q.push_back(rec);
        end
        n_pending = exp_q.size();
    end

endmodule

/* tb_rv_core.sv */
`timescale 1ns/10ps

`include "rv_core_consts.svh"

module tb_rv_core
    import rv_core_pkg::*;
();

    localparam int TIMEOUT  = 200;  // cycles allowed for any single wait
    localparam int MAX_ROWS = 64;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   in_valid;
    logic                   in_ready;
    logic [`XLEN-1:0]       in_insn;
    logic [`XLEN-1:0]       in_pc;
    logic                   retire_valid;
    logic                   retire_ready;
    logic [`XLEN-1:0]       retire_pc;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic                   retire_we;
    logic [`XLEN-1:0]       retire_data;
    logic                   retire_br_taken;
    logic [`XLEN-1:0]       retire_br_target;
    exc_e                   retire_exc;
    logic                   exp_push;
    logic [`XLEN-1:0]       exp_pc;
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic                   exp_we;
    logic [`XLEN-1:0]       exp_data;
    logic                   exp_taken;
    logic [`XLEN-1:0]       exp_target;
    exc_e                   exp_exc;
    int                     n_pass;
    int                     n_fail;
    int                     n_pending;
    logic                   bp_en;      // random retire back-pressure
    logic                   timed_out;

    // stimulus table, one row per instruction
    logic [`XLEN-1:0]       t_insn   [MAX_ROWS];
    logic [`XLEN-1:0]       t_pc     [MAX_ROWS];
    logic [`REG_ADDR_W-1:0] t_rd     [MAX_ROWS];
    logic                   t_we     [MAX_ROWS];
    logic [`XLEN-1:0]       t_data   [MAX_ROWS];
    logic                   t_taken  [MAX_ROWS];
    logic [`XLEN-1:0]       t_target [MAX_ROWS];
    exc_e                   t_exc    [MAX_ROWS];
    int                     n_rows;

    always #4 clk = ~clk;

    always @(posedge clk) begin
        #1;
        retire_ready = bp_en ? ($urandom % 100 < 60) : 1'b1;  // ready about 60% of cycles
    end

    rv_core         i_rv_core (.*);
    rv_core_checker i_checker (.*);

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                           int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OP_REG};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                           int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] u_type(logic [6:0] opc, int rd, logic [19:0] imm);
        return {imm, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] row_pc(int idx);
        return 32'h100 + 4 * idx;
    endfunction

    task automatic put_row(input logic [31:0] insn, input int rd, input logic we,
                           input logic [31:0] data, input logic taken,
                           input logic [31:0] target, input exc_e exc);
        t_insn[n_rows]   = insn;
        t_pc[n_rows]     = row_pc(n_rows);
        t_rd[n_rows]     = rd[4:0];
        t_we[n_rows]     = we;
        t_data[n_rows]   = data;
        t_taken[n_rows]  = taken;
        t_target[n_rows] = target;
        t_exc[n_rows]    = exc;
        n_rows++;
    endtask

    task automatic alu_row(input logic [31:0] insn, input int rd, input logic [31:0] data);
        put_row(insn, rd, 1'b1, data, 1'b0, '0, EXC_NONE);
    endtask

    // target is pc plus the B immediate, no register write
    task automatic branch_row(input logic [2:0] f3, input int rs1, input int rs2, input int off,
                              input logic taken);
        put_row(b_type(f3, rs1, rs2, off), 0, 1'b0, '0, taken, row_pc(n_rows) + off, EXC_NONE);
    endtask

    task automatic undef_row(input logic [31:0] insn);
        put_row(insn, 0, 1'b0, '0, 1'b0, '0, EXC_UNDEF_INSN);
    endtask

    task automatic build_table();
        n_rows = 0;
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 1, 0, -5), 1, 32'hffff_fffb);
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 4, 0, 7), 4, 32'h0000_0007);
        alu_row(i_type(`OP_IMM, `FUNCT3_SLT, 2, 4, -1), 2, 32'h0000_0000);   // 7 < -1 signed
        alu_row(i_type(`OP_IMM, `FUNCT3_SLTU, 3, 4, -1), 3, 32'h0000_0001);
        alu_row(i_type(`OP_IMM, `FUNCT3_SRL_SRA, 5, 1, 'h402), 5, 32'hffff_fffe);  // srai 2
        alu_row(i_type(`OP_IMM, `FUNCT3_SRL_SRA, 6, 1, 2), 6, 32'h3fff_fffe);
        alu_row(u_type(`OP_LUI, 7, 20'h12345), 7, 32'h1234_5000);
        alu_row(u_type(`OP_AUIPC, 8, 20'h00001), 8, row_pc(7) + 32'h1000);
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 9, 4, 1), 9, 32'h0000_0002);
        alu_row(r_type(`FUNCT7_ALT, `FUNCT3_ADD_SUB, 10, 4, 1), 10, 32'h0000_000c);
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_SLT, 11, 1, 4), 11, 32'h0000_0001);
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_SLTU, 12, 1, 4), 12, 32'h0000_0000);
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_AND, 13, 1, 4), 13, 32'h0000_0003);
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 16, 0, 35), 16, 32'h0000_0023);
        // shift amounts come from the low 5 bits of x16, so 3
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_SLL, 17, 4, 16), 17, 32'h0000_0038);
        alu_row(r_type(`FUNCT7_ALT, `FUNCT3_SRL_SRA, 18, 1, 16), 18, 32'hffff_ffff);
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_SRL_SRA, 19, 1, 16), 19, 32'h1fff_ffff);
        // dependent chain at distance 1 and 2
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 20, 0, 100), 20, 32'h0000_0064);
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 20, 20, 20), 20, 32'h0000_00c8);
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 21, 20, 1), 21, 32'h0000_00c9);
        alu_row(r_type(`FUNCT7_ALT, `FUNCT3_ADD_SUB, 22, 20, 21), 22, 32'hffff_ffff);
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 20, 22, 20), 20, 32'h0000_00c7);
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 0, 0, 5), 0, 32'h0000_0005);
        alu_row(r_type(`FUNCT7_BASE, `FUNCT3_ADD_SUB, 23, 0, 0), 23, 32'h0000_0000);
        // x1 holds -5 and x4 holds 7
        branch_row(`FUNCT3_BEQ, 4, 4, 16, 1'b1);
        branch_row(`FUNCT3_BEQ, 1, 4, 16, 1'b0);
        branch_row(`FUNCT3_BNE, 1, 4, -8, 1'b1);
        branch_row(`FUNCT3_BNE, 4, 4, -8, 1'b0);
        branch_row(`FUNCT3_BLT, 1, 4, 16, 1'b1);
        branch_row(`FUNCT3_BLT, 4, 1, 16, 1'b0);
        branch_row(`FUNCT3_BGE, 4, 1, -8, 1'b1);
        branch_row(`FUNCT3_BGE, 1, 4, -8, 1'b0);
        branch_row(`FUNCT3_BLTU, 4, 1, 16, 1'b1);
        branch_row(`FUNCT3_BLTU, 1, 4, 16, 1'b0);
        branch_row(`FUNCT3_BGEU, 1, 4, -8, 1'b1);
        branch_row(`FUNCT3_BGEU, 4, 1, -8, 1'b0);
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 24, 0, 7), 24, 32'h0000_0007);
        branch_row(`FUNCT3_BEQ, 24, 4, 16, 1'b1);
        undef_row(r_type(7'b0000001, `FUNCT3_ADD_SUB, 9, 4, 4));
        undef_row(i_type(7'b0000011, `FUNCT3_SLT, 10, 0, 0));   // load opcode, not kept
        undef_row(i_type(`OP_IMM, `FUNCT3_SLL, 11, 1, 'h401));
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 26, 11, 0), 26, 32'h0000_0001);
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 27, 10, 0), 27, 32'h0000_000c);
        alu_row(i_type(`OP_IMM, `FUNCT3_ADD_SUB, 28, 9, 0), 28, 32'h0000_0002);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_row(input int r);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_insn  = t_insn[r];
        in_pc    = t_pc[r];
        @(negedge clk);
        while (!in_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("timeout: row %0d was not accepted within %0d cycles", r, TIMEOUT);
            timed_out = 1'b1;
        end else begin
            exp_push   = 1'b1;  // queued on the same edge that accepts the row
            exp_pc     = t_pc[r];
            exp_rd     = t_rd[r];
            exp_we     = t_we[r];
            exp_data   = t_data[r];
            exp_taken  = t_taken[r];
            exp_target = t_target[r];
            exp_exc    = t_exc[r];
            @(posedge clk);
            #1;
            exp_push = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (n_pending != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (n_pending != 0) begin
            $display("timeout: %0d expected retirements never arrived", n_pending);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'h9a1f));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_insn      = '0;
        in_pc        = '0;
        retire_ready = 1'b1;
        bp_en        = 1'b0;
        timed_out    = 1'b0;
        exp_push     = 1'b0;
        exp_pc       = '0;
        exp_rd       = '0;
        exp_we       = 1'b0;
        exp_data     = '0;
        exp_taken    = 1'b0;
        exp_target   = '0;
        exp_exc      = EXC_NONE;
        build_table();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // first pass with retire_ready high, second with random stalls
        for (int pass_idx = 0; pass_idx < 2 && !timed_out; pass_idx++) begin
            if (pass_idx > 0) begin
                bp_en = 1'b1;
                @(posedge clk);
                #1;
            end
            for (int r = 0; r < n_rows && !timed_out; r++) begin
                send_row(r);
            end
            in_valid = 1'b0;
            if (!timed_out) begin
                wait_drain();
            end
        end
        bp_en = 1'b0;
        repeat (4) @(negedge clk);  // catch stray retirements
        $display("retirement checks: %0d ok, %0d failed", n_pass, n_fail);
        if (!timed_out && n_fail == 0 && n_pass == 2 * n_rows) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+.
rv_core_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_core_checker.sv
tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# build the rv_core testbench with Verilator, run it, and judge from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_rv_core -f rv_core.f \
    && ./obj_dir/Vtb_rv_core > sim.log 2>&1 \
    || echo "build or run did not complete"

cat sim.log 2>/dev/null
grep -qx "SIMULATION PASSED" sim.log 2>/dev/null && exit 0 || exit 1
